// ==== Bender.yml ====
package:
  name: spi_io

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spi_io_pkg.sv
      - spi_req_dispatch.sv
      - spi_channel.sv
      - spi_rsp_merge.sv
      - spi_io_top.sv
      - target: test
        include_dirs:
          - .
        files:
          - tb_spi_io_checker.sv
          - tb_spi_io.sv

// ==== build.f ====
+incdir+.
spi_io_pkg.sv
spi_req_dispatch.sv
spi_channel.sv
spi_rsp_merge.sv
spi_io_top.sv
tb_spi_io_checker.sv
tb_spi_io.sv

// ==== spi_channel.sv ====
// One SPI master channel with its registers, mode-0 shift engine and response slot
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module spi_channel (
   input  wire                       clk,
   input  wire                       i_rst,
   input  wire                       i_req_valid,
   input  wire spi_io_pkg::spi_req_t i_req,
   input  wire                       i_rsp_ack,
   input  wire                       i_miso,
   output logic                      o_ready,
   output logic                      o_rsp_valid,
   output spi_io_pkg::spi_rsp_t      o_rsp,
   output spi_io_pkg::spi_pins_t     o_pins
);

   import spi_io_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_RESP
   } state_e;

   localparam int BCNT_W = $clog2(`DATA_W + 1);

   state_e             state;
   spi_ctrl_t          ctrl;
   logic [`DATA_W-1:0] last_rx;
   logic [`DATA_W-1:0] xfer_cnt;
   logic [`DATA_W-1:0] tx_sh;
   logic [`DATA_W-1:0] rx_sh;
   logic [3:0]         div_cnt;
   logic [BCNT_W-1:0]  bit_cnt;
   spi_pins_t          pins;
   spi_rsp_t           rsp;
   logic               req_take;
   logic               data_wr;
   logic               xfer_done;
   logic               half_tick;

   assign req_take  = (state == ST_IDLE) && i_req_valid;
   assign data_wr   = (i_req.op == OP_WRITE) && (i_req.reg_sel == REG_DATA);
   assign xfer_done = (state == ST_SHIFT) && (bit_cnt == BCNT_W'(`DATA_W));
   assign half_tick = (state == ST_SHIFT) && !xfer_done && (div_cnt == '0);

   // Idle means the response slot is empty as well
   assign o_ready     = (state == ST_IDLE);
   assign o_rsp_valid = (state == ST_RESP);
   assign o_rsp       = rsp;
   assign o_pins      = pins;

   //********************
   // Control and FSM
   //********************

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state     <= ST_IDLE;
         ctrl      <= '0;
         last_rx   <= '0;
         xfer_cnt  <= '0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
         pins.sclk <= 1'b0;
         pins.cs_n <= 1'b1;
         pins.mosi <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_req_valid && data_wr) begin
                  state     <= ST_SHIFT;
                  div_cnt   <= ctrl.div;
                  bit_cnt   <= '0;
                  pins.cs_n <= ~ctrl.sel;
                  pins.mosi <= i_req.data[`DATA_W-1];
               end else if (i_req_valid) begin
                  state <= ST_RESP;
                  if (i_req.op == OP_WRITE && i_req.reg_sel == REG_CTRL) begin
                     ctrl.sel  <= i_req.data[7];
                     ctrl.rsvd <= 3'b000;
                     ctrl.div  <= i_req.data[3:0];
                  end
               end
            end
            ST_SHIFT: begin
               if (xfer_done) begin
                  state     <= ST_RESP;
                  last_rx   <= rx_sh;
                  xfer_cnt  <= xfer_cnt + 1'b1;
                  pins.cs_n <= 1'b1;
                  pins.mosi <= 1'b0;
               end else if (half_tick) begin
                  div_cnt   <= ctrl.div;
                  pins.sclk <= ~pins.sclk;
                  // Falling edge, next bit out unless this was the last one
                  if (pins.sclk) begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt != BCNT_W'(`DATA_W - 1)) begin
                        pins.mosi <= tx_sh[`DATA_W-2];
                     end
                  end
               end else begin
                  div_cnt <= div_cnt - 1'b1;
               end
            end
            ST_RESP: begin
               if (i_rsp_ack) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   //********************
   // Shift and response data
   //********************

   always_ff @(posedge clk) begin
      if (req_take) begin
         tx_sh    <= i_req.data;
         rsp.chan <= i_req.chan;
         rsp.tag  <= i_req.tag;
         rsp.err  <= 1'b0;
         rsp.data <= '0;
         case (i_req.reg_sel)
            REG_CTRL: begin
               if (i_req.op == OP_READ) begin
                  rsp.data <= `DATA_W'(ctrl);
               end
            end
            REG_DATA:   rsp.data <= last_rx;
            REG_STATUS: begin
               if (i_req.op == OP_WRITE) begin
                  rsp.err <= 1'b1;
               end else begin
                  rsp.data <= xfer_cnt;
               end
            end
            default: rsp.data <= '0;
         endcase
      end else if (xfer_done) begin
         rsp.data <= rx_sh;
      end else if (half_tick) begin
         // Sample on rise, shift on fall
         if (!pins.sclk) begin
            rx_sh <= {rx_sh[`DATA_W-2:0], i_miso};
         end else begin
            tx_sh <= {tx_sh[`DATA_W-2:0], 1'b0};
         end
      end
   end

endmodule

`default_nettype wire

// ==== spi_io_pkg.sv ====
// Opcode and register enums, control, request, response and pin structs
`default_nettype none

`include "spi_io_settings.svh"

package spi_io_pkg;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } spi_op_e;

   typedef enum logic [1:0] {
      REG_CTRL,
      REG_DATA,
      REG_STATUS
   } spi_reg_e;

   // Control register layout, reserved bits read as zero
   typedef struct packed {
      logic       sel;
      logic [2:0] rsvd;
      logic [3:0] div;
   } spi_ctrl_t;

   typedef struct packed {
      logic [`CHAN_W-1:0] chan;
      spi_op_e            op;
      spi_reg_e           reg_sel;
      logic [`TAG_W-1:0]  tag;
      logic [`DATA_W-1:0] data;
   } spi_req_t;

   typedef struct packed {
      logic [`CHAN_W-1:0] chan;
      logic [`TAG_W-1:0]  tag;
      logic               err;
      logic [`DATA_W-1:0] data;
   } spi_rsp_t;

   typedef struct packed {
      logic sclk;
      logic cs_n;
      logic mosi;
   } spi_pins_t;

endpackage

`default_nettype wire

// ==== spi_io_settings.svh ====
// Channel count, field widths and credit depths for the SPI I/O block
`ifndef SPI_IO_SETTINGS_SVH
`define SPI_IO_SETTINGS_SVH

// Number of SPI master channels and width of a channel index
`define NUM_CHAN 4
`define CHAN_W 2

// Request tag and data byte widths
`define TAG_W 4
`define DATA_W 8

// Request FIFO depth, also the host's credits after reset
`define REQ_CREDITS 4

// Response credits held by the merger after reset
`define RSP_CREDITS 4

`endif

// ==== spi_io_top.sv ====
// Top level with the request dispatcher, the SPI channel array and the response merger
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module spi_io_top (
   input  wire                                        clk,
   input  wire                                        i_rst,
   input  wire                                        i_req_valid,
   input  wire spi_io_pkg::spi_req_t                  i_req,
   input  wire                                        i_rsp_credit,
   input  wire [`NUM_CHAN-1:0]                        i_miso,
   output wire                                        o_req_credit,
   output wire                                        o_rsp_valid,
   output wire spi_io_pkg::spi_rsp_t                  o_rsp,
   output wire spi_io_pkg::spi_pins_t [`NUM_CHAN-1:0] o_pins
);

   import spi_io_pkg::*;

   wire                          [`NUM_CHAN-1:0] chan_ready;
   wire                          [`NUM_CHAN-1:0] chan_req_valid;
   wire spi_req_t                                chan_req;
   wire                          [`NUM_CHAN-1:0] chan_rsp_valid;
   wire spi_rsp_t                [`NUM_CHAN-1:0] chan_rsp;
   wire                          [`NUM_CHAN-1:0] chan_ack;

   spi_req_dispatch u_dispatch (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .i_chan_ready (chan_ready),
      .o_req_credit (o_req_credit),
      .o_chan_valid (chan_req_valid),
      .o_chan_req   (chan_req)
   );

   // Identical channels, request bus shared and qualified per channel
   for (genvar g = 0; g < `NUM_CHAN; g++) begin : g_chan
      spi_channel u_chan (
         .clk         (clk),
         .i_rst       (i_rst),
         .i_req_valid (chan_req_valid[g]),
         .i_req       (chan_req),
         .i_rsp_ack   (chan_ack[g]),
         .i_miso      (i_miso[g]),
         .o_ready     (chan_ready[g]),
         .o_rsp_valid (chan_rsp_valid[g]),
         .o_rsp       (chan_rsp[g]),
         .o_pins      (o_pins[g])
      );
   end

   spi_rsp_merge u_merge (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_chan_valid (chan_rsp_valid),
      .i_chan_rsp   (chan_rsp),
      .i_rsp_credit (i_rsp_credit),
      .o_chan_ack   (chan_ack),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp)
   );

endmodule

`default_nettype wire

// ==== spi_req_dispatch.sv ====
// Request FIFO, request credit return and per-channel request routing
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module spi_req_dispatch (
   input  wire                                 clk,
   input  wire                                 i_rst,
   input  wire                                 i_req_valid,
   input  wire spi_io_pkg::spi_req_t           i_req,
   input  wire [`NUM_CHAN-1:0]                 i_chan_ready,
   output logic                                o_req_credit,
   output logic [`NUM_CHAN-1:0]                o_chan_valid,
   output spi_io_pkg::spi_req_t                o_chan_req
);

   import spi_io_pkg::*;

   localparam int PTR_W = (`REQ_CREDITS > 1) ? $clog2(`REQ_CREDITS) : 1;
   localparam int CNT_W = $clog2(`REQ_CREDITS + 1);

   spi_req_t         mem [`REQ_CREDITS];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   spi_req_t         head;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(`REQ_CREDITS - 1)) ? '0 : p + 1'b1;
   endfunction

   //********************
   // Head routing
   //********************

   assign head = mem[rd_ptr];

   // Head leaves only when its own channel can take it
   assign pop = (count != '0) && i_chan_ready[head.chan];

   always_comb begin
      o_chan_valid = '0;
      if (pop) begin
         o_chan_valid[head.chan] = 1'b1;
      end
   end

   assign o_chan_req = head;

   //********************
   // FIFO storage
   //********************

   always_ff @(posedge clk) begin
      if (i_req_valid) begin
         mem[wr_ptr] <= i_req;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         o_req_credit <= 1'b0;
      end else begin
         if (i_req_valid) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({i_req_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One credit back per entry popped
         o_req_credit <= pop;
      end
   end

endmodule

`default_nettype wire

// ==== spi_rsp_merge.sv ====
// Round-robin merge of channel responses onto the host port under response credits
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module spi_rsp_merge (
   input  wire                                       clk,
   input  wire                                       i_rst,
   input  wire [`NUM_CHAN-1:0]                       i_chan_valid,
   input  wire spi_io_pkg::spi_rsp_t [`NUM_CHAN-1:0] i_chan_rsp,
   input  wire                                       i_rsp_credit,
   output logic [`NUM_CHAN-1:0]                      o_chan_ack,
   output logic                                      o_rsp_valid,
   output spi_io_pkg::spi_rsp_t                      o_rsp
);

   import spi_io_pkg::*;

   localparam int CRD_W = $clog2(`RSP_CREDITS + 1);

   logic [`CHAN_W-1:0] rr_ptr;
   logic [`CHAN_W-1:0] gnt_idx;
   logic               gnt_vld;
   logic [CRD_W-1:0]   credit_cnt;
   spi_rsp_t           gnt_rsp;

   // Search from the pointer, nothing granted without a credit
   always_comb begin
      int idx;
      idx     = 0;
      gnt_vld = 1'b0;
      gnt_idx = rr_ptr;
      if (credit_cnt != '0) begin
         for (int i = 0; i < `NUM_CHAN; i++) begin
            idx = (int'(rr_ptr) + i) % `NUM_CHAN;
            if (!gnt_vld && i_chan_valid[idx]) begin
               gnt_vld = 1'b1;
               gnt_idx = `CHAN_W'(idx);
            end
         end
      end
   end

   assign o_chan_ack = gnt_vld ? (`NUM_CHAN'(1) << gnt_idx) : '0;
   assign gnt_rsp    = i_chan_rsp[gnt_idx];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         rr_ptr      <= '0;
         credit_cnt  <= CRD_W'(`RSP_CREDITS);
         o_rsp_valid <= 1'b0;
      end else begin
         o_rsp_valid <= gnt_vld;
         if (gnt_vld) begin
            rr_ptr <= (gnt_idx == `CHAN_W'(`NUM_CHAN - 1)) ? '0 : gnt_idx + 1'b1;
         end
         case ({gnt_vld, i_rsp_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (gnt_vld) begin
         o_rsp <= gnt_rsp;
      end
   end

endmodule

`default_nettype wire

// ==== tb_spi_io.sv ====
// Testbench top with clock, reset, LFSR stimulus, SPI slave models and credit handling
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module tb_spi_io;

   import spi_io_pkg::*;

   localparam int N_DIRECTED  = 16;
   localparam int N_RAND      = 64;
   localparam int TIMEOUT_CYC = (N_DIRECTED + N_RAND) * 300 + 1000;

   logic                              clk;
   logic                              rst;
   logic                              req_valid;
   spi_req_t                          req;
   logic                              rsp_credit;
   logic                              final_chk;
   wire [`NUM_CHAN-1:0]               miso;
   wire                               req_credit;
   wire                               rsp_valid;
   wire spi_rsp_t                     rsp;
   wire spi_pins_t [`NUM_CHAN-1:0]    pins;
   int                                chk_errors;
   int                                chk_checks;
   int                                chk_pending;

   logic [31:0]        lfsr;
   logic               withhold;
   logic [`TAG_W-1:0]  tag_ctr;
   int                 req_spent;
   int                 credit_got;
   int                 rsp_seen;
   int                 rsp_returned;
   int                 err_mark;
   int                 cycles;

   spi_io_top uut (
      .clk          (clk),
      .i_rst        (rst),
      .i_req_valid  (req_valid),
      .i_req        (req),
      .i_rsp_credit (rsp_credit),
      .i_miso       (miso),
      .o_req_credit (req_credit),
      .o_rsp_valid  (rsp_valid),
      .o_rsp        (rsp),
      .o_pins       (pins)
   );

   tb_spi_io_checker chk (
      .clk          (clk),
      .i_rst        (rst),
      .i_req_valid  (req_valid),
      .i_req        (req),
      .i_req_credit (req_credit),
      .i_rsp_valid  (rsp_valid),
      .i_rsp        (rsp),
      .i_rsp_credit (rsp_credit),
      .i_pins       (pins),
      .i_final      (final_chk),
      .o_errors     (chk_errors),
      .o_checks     (chk_checks),
      .o_pending    (chk_pending)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //********************
   // SPI slave models
   //********************

   for (genvar g = 0; g < `NUM_CHAN; g++) begin : g_slave
      wire        sclk = pins[g].sclk;
      wire        cs_n = pins[g].cs_n;
      wire        mosi = pins[g].mosi;
      logic [7:0] stored;
      logic [7:0] tx;
      logic [7:0] rx;
      logic       so;

      assign miso[g] = so;

      initial begin
         stored = '0;
         tx     = '0;
         rx     = '0;
         so     = 1'b1;
      end

      // Reply is the previous byte XOR the channel index
      always @(negedge cs_n) begin
         tx = stored ^ 8'(g);
         so = tx[7];
      end

      always @(posedge sclk) begin
         if (!cs_n) begin
            rx = {rx[6:0], mosi};
         end
      end

      always @(negedge sclk) begin
         if (!cs_n) begin
            tx = {tx[6:0], 1'b0};
            so = tx[7];
         end
      end

      always @(posedge cs_n) begin
         stored = rx;
         so     = 1'b1;
      end
   end

   //********************
   // Credits and timeout
   //********************

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (!rst) begin
         if (req_credit) begin
            credit_got <= credit_got + 1;
         end
         if (rsp_valid) begin
            rsp_seen <= rsp_seen + 1;
         end
      end
      if (cycles >= TIMEOUT_CYC) begin
         $display("timeout: run stopped after %0d cycles with work outstanding", cycles);
         $display("sim failed");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic int req_credits();
      return `REQ_CREDITS + credit_got - req_spent;
   endfunction

   // One falling edge, pulses cleared, maybe one response credit back
   task automatic step();
      logic [7:0] coin;
      @(negedge clk);
      req_valid  = 1'b0;
      rsp_credit = 1'b0;
      final_chk  = 1'b0;
      if (rsp_seen > rsp_returned) begin
         coin = withhold ? take_bits(1) : 8'd1;
         if (coin[0]) begin
            rsp_credit   = 1'b1;
            rsp_returned = rsp_returned + 1;
         end
      end
   endtask

   task automatic send_req(input logic [`CHAN_W-1:0] c, input spi_op_e op,
                           input spi_reg_e rs, input logic [7:0] d);
      step();
      while (req_credits() == 0) begin
         step();
      end
      req_valid = 1'b1;
      req       = '{chan: c, op: op, reg_sel: rs, tag: tag_ctr, data: d};
      tag_ctr   = tag_ctr + 1'b1;
      req_spent = req_spent + 1;
   endtask

   task automatic end_test(input string name);
      withhold = 1'b0;
      while (req_valid || chk_pending != 0 || rsp_seen != rsp_returned) begin
         step();
      end
      $display("test %s: %0d errors", name, chk_errors - err_mark);
      err_mark = chk_errors;
   endtask

   //********************
   // Test sequence
   //********************

   initial begin
      logic [7:0]         bits;
      logic [`CHAN_W-1:0] chan;
      spi_op_e            op;
      spi_reg_e           rs;
      logic [7:0]         data;
      lfsr         = 32'd70622;
      rst          = 1'b1;
      req_valid    = 1'b0;
      req          = '0;
      rsp_credit   = 1'b0;
      final_chk    = 1'b0;
      withhold     = 1'b0;
      tag_ctr      = '0;
      req_spent    = 0;
      rsp_returned = 0;
      err_mark     = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      step();
      step();
      end_test("1 reset state");

      send_req(2'd0, OP_WRITE, REG_CTRL, 8'hFA);
      send_req(2'd0, OP_READ, REG_CTRL, 8'h00);
      send_req(2'd0, OP_WRITE, REG_STATUS, 8'h55);
      send_req(2'd0, OP_READ, REG_STATUS, 8'h00);
      end_test("2 registers");

      send_req(2'd2, OP_WRITE, REG_CTRL, 8'h81);
      send_req(2'd2, OP_WRITE, REG_DATA, 8'h5A);
      send_req(2'd2, OP_WRITE, REG_DATA, 8'hC3);
      send_req(2'd2, OP_READ, REG_DATA, 8'h00);
      send_req(2'd2, OP_READ, REG_STATUS, 8'h00);
      send_req(2'd3, OP_WRITE, REG_CTRL, 8'h80);
      send_req(2'd3, OP_WRITE, REG_DATA, 8'h11);
      end_test("3 selected transfers");

      // Slave on channel 2 must still hold 0xC3 afterwards
      send_req(2'd2, OP_WRITE, REG_CTRL, 8'h03);
      send_req(2'd2, OP_WRITE, REG_DATA, 8'h77);
      send_req(2'd2, OP_WRITE, REG_CTRL, 8'h80);
      send_req(2'd2, OP_WRITE, REG_DATA, 8'h99);
      send_req(2'd2, OP_READ, REG_STATUS, 8'h00);
      end_test("4 deselected transfer");

      withhold = 1'b1;
      for (int n = 0; n < N_RAND; n++) begin
         bits = take_bits(2);
         chan = bits[`CHAN_W-1:0];
         bits = take_bits(1);
         op   = spi_op_e'(bits[0]);
         bits = take_bits(2);
         rs   = (bits[1:0] == 2'd3) ? REG_DATA : spi_reg_e'(bits[1:0]);
         data = take_bits(8);
         send_req(chan, op, rs, data);
      end
      end_test("5 random traffic");

      step();
      final_chk = 1'b1;
      step();
      step();
      end_test("6 credit return");

      $display("checks %0d, errors %0d, requests %0d", chk_checks, chk_errors, req_spent);
      if (chk_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_spi_io_checker.sv ====
// Checker with the reference model, per-channel expected queues and credit accounting
`timescale 1ns/1ps
`default_nettype none

`include "spi_io_settings.svh"

module tb_spi_io_checker (
   input  wire                                        clk,
   input  wire                                        i_rst,
   input  wire                                        i_req_valid,
   input  wire spi_io_pkg::spi_req_t                  i_req,
   input  wire                                        i_req_credit,
   input  wire                                        i_rsp_valid,
   input  wire spi_io_pkg::spi_rsp_t                  i_rsp,
   input  wire                                        i_rsp_credit,
   input  wire spi_io_pkg::spi_pins_t [`NUM_CHAN-1:0] i_pins,
   input  wire                                        i_final,
   output int                                         o_errors,
   output int                                         o_checks,
   output int                                         o_pending
);

   import spi_io_pkg::*;

   typedef struct packed {
      logic     sel;
      spi_rsp_t rsp;
   } expect_t;

   expect_t            exp_q [`NUM_CHAN][$];
   spi_ctrl_t          ctrl_m [`NUM_CHAN];
   logic [`DATA_W-1:0] last_m [`NUM_CHAN];
   logic [`DATA_W-1:0] cnt_m [`NUM_CHAN];
   logic [`DATA_W-1:0] slave_m [`NUM_CHAN];
   int                 req_seen;
   int                 credits_back;
   int                 rsp_owed;
   logic               rst_d;

   // Register and slave model updated in request order
   function automatic expect_t reference(input spi_req_t r);
      expect_t            e;
      int                 c;
      logic [`DATA_W-1:0] d;
      c          = int'(r.chan);
      d          = '0;
      e.sel      = ctrl_m[c].sel;
      e.rsp.chan = r.chan;
      e.rsp.tag  = r.tag;
      e.rsp.err  = 1'b0;
      case (r.reg_sel)
         REG_CTRL: begin
            if (r.op == OP_WRITE) begin
               ctrl_m[c] = '{sel: r.data[7], rsvd: 3'b000, div: r.data[3:0]};
            end else begin
               d = ctrl_m[c];
            end
         end
         REG_DATA: begin
            if (r.op == OP_READ) begin
               d = last_m[c];
            end else begin
               // Deselected slave keeps its byte and miso idles high
               d = ctrl_m[c].sel ? (slave_m[c] ^ `DATA_W'(c)) : '1;
               if (ctrl_m[c].sel) begin
                  slave_m[c] = r.data;
               end
               last_m[c] = d;
               cnt_m[c]  = cnt_m[c] + 1'b1;
            end
         end
         REG_STATUS: begin
            if (r.op == OP_WRITE) begin
               e.rsp.err = 1'b1;
            end else begin
               d = cnt_m[c];
            end
         end
         default: d = '0;
      endcase
      e.rsp.data = d;
      return e;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
      o_checks = o_checks + 1;
      if (got !== want) begin
         o_errors = o_errors + 1;
         $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, want);
      end
   endtask

   task automatic report(input string msg);
      o_errors = o_errors + 1;
      $display("error at %0t: %s", $time, msg);
   endtask

   always @(posedge clk) begin
      expect_t e;
      int      c;
      int      n;
      rst_d <= i_rst;
      if (i_rst) begin
         for (int i = 0; i < `NUM_CHAN; i++) begin
            ctrl_m[i]  = '0;
            last_m[i]  = '0;
            cnt_m[i]   = '0;
            slave_m[i] = '0;
         end
         req_seen     = 0;
         credits_back = 0;
         rsp_owed     = 0;
      end else begin
         if (rst_d) begin
            compare("o_req_credit", 32'(i_req_credit), 32'd0);
            compare("o_rsp_valid", 32'(i_rsp_valid), 32'd0);
            for (int i = 0; i < `NUM_CHAN; i++) begin
               compare($sformatf("o_pins[%0d].cs_n", i), 32'(i_pins[i].cs_n), 32'd1);
               compare($sformatf("o_pins[%0d].sclk", i), 32'(i_pins[i].sclk), 32'd0);
               compare($sformatf("o_pins[%0d].mosi", i), 32'(i_pins[i].mosi), 32'd0);
            end
         end
         if (i_req_valid) begin
            exp_q[i_req.chan].push_back(reference(i_req));
            req_seen = req_seen + 1;
         end
         if (i_req_credit) begin
            credits_back = credits_back + 1;
         end
         if (i_rsp_credit) begin
            rsp_owed = rsp_owed - 1;
         end
         if (i_rsp_valid) begin
            rsp_owed = rsp_owed + 1;
            c        = int'(i_rsp.chan);
            if (exp_q[c].size() == 0) begin
               report($sformatf("response on channel %0d with no request outstanding", c));
            end else begin
               e = exp_q[c].pop_front();
               compare("o_rsp.tag", 32'(i_rsp.tag), 32'(e.rsp.tag));
               compare("o_rsp.err", 32'(i_rsp.err), 32'(e.rsp.err));
               compare("o_rsp.data", 32'(i_rsp.data), 32'(e.rsp.data));
            end
         end
         if (rsp_owed > `RSP_CREDITS) begin
            report($sformatf("%0d responses sent without a credit", rsp_owed));
         end
         for (int i = 0; i < `NUM_CHAN; i++) begin
            if (!i_pins[i].cs_n && (exp_q[i].size() == 0 || !exp_q[i][0].sel)) begin
               report($sformatf("cs_n low on channel %0d without a selected transfer", i));
            end
         end
         if (i_final) begin
            compare("o_req_credit pulses", 32'(credits_back), 32'(req_seen));
            for (int i = 0; i < `NUM_CHAN; i++) begin
               if (exp_q[i].size() != 0) begin
                  report($sformatf("channel %0d still owes %0d responses", i, exp_q[i].size()));
               end
            end
         end
      end
      n = 0;
      for (int i = 0; i < `NUM_CHAN; i++) begin
         n = n + exp_q[i].size();
      end
      o_pending = n;
   end

endmodule

`default_nettype wire
